/* Makefile */
TOP = tb_int_exec_core

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f int_exec_core.f -o sim

run: compile
	./obj_dir/sim +verilator+error+limit+100 | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

/* int_exec_core.f */
src/exec_pkg.sv
src/inst_decoder.sv
src/reg_file.sv
src/pipe_reg.sv
src/operand_sel.sv
src/int_alu.sv
src/exec_ctrl.sv
src/int_exec_core.sv
tb/int_exec_checker.sv
tb/tb_int_exec_core.sv

/* src/exec_ctrl.sv */
`timescale 1ns/100ps

module exec_ctrl import exec_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      ex_valid,
    input  logic      ex_illegal,
    input  reg_addr_t ex_rs1,
    input  reg_addr_t ex_rs2,
    input  src_a_e    ex_src_a,
    input  src_b_e    ex_src_b,
    input  logic      wb_valid_q,
    input  reg_addr_t wb_rd_q,
    output logic      id_load,
    output logic      wb_load,
    output logic      rf_wen,
    output logic      fwd_a,
    output logic      fwd_b,
    output logic      halt
);

    logic wb_live; // wb stage holds a result for a real register

    assign wb_live = wb_valid_q && (wb_rd_q != '0);

    // sticky until reset
    always_ff @(posedge clk) begin
        if (!rst) begin
            halt <= 1'b0;
        end else if (ex_valid && ex_illegal) begin
            halt <= 1'b1;
        end
    end

    assign id_load = !halt;
    assign wb_load = ex_valid && !ex_illegal && !halt; // illegal never reaches wb

    assign rf_wen = wb_live;

    // bypass the wb result into a directly dependent instruction
    assign fwd_a = wb_live && (wb_rd_q == ex_rs1) && (ex_src_a == src_rs1);
    assign fwd_b = wb_live && (wb_rd_q == ex_rs2) && (ex_src_b == src_rs2);

endmodule

/* src/exec_pkg.sv */
package exec_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // major opcodes kept by this core
    localparam logic [6:0] op_reg   = 7'b0110011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;

    // funct3 of the arithmetic groups
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000; // sub, sra

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b // lui
    } alu_op_e;

    typedef enum logic {
        src_rs1,
        src_pc
    } src_a_e;

    typedef enum logic {
        src_rs2,
        src_imm
    } src_b_e;

    // decode stage payload
    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        alu_op_e   alu_op;
        src_a_e    src_a;
        src_b_e    src_b;
        word_t     imm;
        word_t     pc;
        logic      illegal;
    } decoded_t;

    // write-back stage payload
    typedef struct packed {
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

/* src/inst_decoder.sv */
`timescale 1ns/100ps

module inst_decoder import exec_pkg::*; (
    input  word_t    inst_word,
    input  word_t    inst_pc,
    output decoded_t dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7; // also imm[11:5] for shifts
    word_t      imm_i;
    word_t      imm_u;

    assign opcode = inst_word[6:0];
    assign funct3 = inst_word[14:12];
    assign funct7 = inst_word[31:25];

    assign imm_i = {{20{inst_word[31]}}, inst_word[31:20]}; // sign extended
    assign imm_u = {inst_word[31:12], 12'b0};

    always_comb begin
        dec.rs1     = inst_word[19:15];
        dec.rs2     = inst_word[24:20];
        dec.rd      = inst_word[11:7];
        dec.pc      = inst_pc;
        dec.imm     = imm_i;
        dec.alu_op  = alu_add;
        dec.src_a   = src_rs1;
        dec.src_b   = src_imm;
        dec.illegal = 1'b0;

        case (opcode)
            op_reg: begin
                dec.src_b = src_rs2;
                case (funct3)
                    f3_add_sub: dec.alu_op = (funct7 == funct7_alt) ? alu_sub : alu_add;
                    f3_sll:     dec.alu_op = alu_sll;
                    f3_slt:     dec.alu_op = alu_slt;
                    f3_sltu:    dec.alu_op = alu_sltu;
                    f3_xor:     dec.alu_op = alu_xor;
                    f3_srl_sra: dec.alu_op = (funct7 == funct7_alt) ? alu_sra : alu_srl;
                    f3_or:      dec.alu_op = alu_or;
                    default:    dec.alu_op = alu_and;
                endcase
                // alt funct7 only legal on sub and sra
                if (funct7 == funct7_alt) begin
                    dec.illegal = (funct3 != f3_add_sub) && (funct3 != f3_srl_sra);
                end else if (funct7 != funct7_base) begin
                    dec.illegal = 1'b1;
                end
            end

            op_imm: begin
                case (funct3)
                    f3_add_sub: dec.alu_op = alu_add;
                    f3_sll: begin
                        dec.alu_op  = alu_sll;
                        dec.illegal = (funct7 != funct7_base); // upper imm must be zero
                    end
                    f3_slt:     dec.alu_op = alu_slt;
                    f3_sltu:    dec.illegal = 1'b1; // not supported in imm group
                    f3_xor:     dec.alu_op = alu_xor;
                    f3_srl_sra: begin
                        dec.alu_op  = funct7[5] ? alu_sra : alu_srl;
                        dec.illegal = ({funct7[6], funct7[4:0]} != 6'b0); // only bit 10 allowed
                    end
                    f3_or:      dec.alu_op = alu_or;
                    default:    dec.alu_op = alu_and;
                endcase
            end

            op_lui: begin
                dec.imm    = imm_u;
                dec.alu_op = alu_pass_b;
            end

            op_auipc: begin
                dec.imm   = imm_u;
                dec.src_a = src_pc; // pc + imm_u
            end

            default: dec.illegal = 1'b1; // unknown opcode
        endcase
    end

endmodule

/* src/int_alu.sv */
`timescale 1ns/100ps

module int_alu import exec_pkg::*; (
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << shamt;
            alu_slt:    result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu:   result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = $signed(a) >>> shamt; // sign fill
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_pass_b: result = b; // lui
            default:    result = '0;
        endcase
    end

endmodule

/* src/int_exec_core.sv */
`timescale 1ns/100ps

module int_exec_core import exec_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      inst_valid,
    input  word_t     inst_word,
    input  word_t     inst_pc,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output word_t     wb_data,
    output logic      halt
);

    decoded_t id_dec;     // decoder output
    decoded_t ex_dec;     // execute stage payload
    logic     ex_valid;
    word_t    rf_a;
    word_t    rf_b;
    word_t    op_a;
    word_t    op_b;
    word_t    alu_result;
    wb_t      ex_wb;
    wb_t      wb_q;
    logic     id_load;
    logic     wb_load;
    logic     rf_wen;
    logic     fwd_a;
    logic     fwd_b;

    assign ex_wb   = '{rd: ex_dec.rd, data: alu_result};
    assign wb_rd   = wb_q.rd;
    assign wb_data = wb_q.data;

    inst_decoder dec0 (.inst_word(inst_word), .inst_pc(inst_pc), .dec(id_dec));

    pipe_reg #(.payload_t(decoded_t)) id_stage (
        .clk(clk), .rst(rst), .load(id_load),
        .in_valid(inst_valid), .in_data(id_dec),
        .out_valid(ex_valid), .out_data(ex_dec)
    );

    reg_file rf0 (
        .clk(clk),
        .raddr_a(ex_dec.rs1), .raddr_b(ex_dec.rs2),
        .waddr(wb_rd), .wdata(wb_data), .wen(rf_wen),
        .rdata_a(rf_a), .rdata_b(rf_b)
    );

    operand_sel osel0 (
        .rf_a(rf_a), .rf_b(rf_b), .wb_data_q(wb_data), .dec(ex_dec),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .op_a(op_a), .op_b(op_b)
    );

    int_alu alu0 (.op(ex_dec.alu_op), .a(op_a), .b(op_b), .result(alu_result));

    pipe_reg #(.payload_t(wb_t)) wb_stage (
        .clk(clk), .rst(rst), .load(wb_load),
        .in_valid(ex_valid), .in_data(ex_wb),
        .out_valid(wb_valid), .out_data(wb_q)
    );

    exec_ctrl ctrl0 (
        .clk(clk), .rst(rst),
        .ex_valid(ex_valid), .ex_illegal(ex_dec.illegal),
        .ex_rs1(ex_dec.rs1), .ex_rs2(ex_dec.rs2),
        .ex_src_a(ex_dec.src_a), .ex_src_b(ex_dec.src_b),
        .wb_valid_q(wb_valid), .wb_rd_q(wb_rd),
        .id_load(id_load), .wb_load(wb_load), .rf_wen(rf_wen),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .halt(halt)
    );

endmodule

/* src/operand_sel.sv */
`timescale 1ns/100ps

module operand_sel import exec_pkg::*; (
    input  word_t    rf_a,
    input  word_t    rf_b,
    input  word_t    wb_data_q,
    input  decoded_t dec,
    input  logic     fwd_a,
    input  logic     fwd_b,
    output word_t    op_a,
    output word_t    op_b
);

    always_comb begin
        if (fwd_a) begin
            op_a = wb_data_q; // result of previous instruction
        end else if (dec.src_a == src_pc) begin
            op_a = dec.pc; // auipc
        end else begin
            op_a = rf_a;
        end
    end

    always_comb begin
        if (fwd_b) begin
            op_b = wb_data_q;
        end else if (dec.src_b == src_imm) begin
            op_b = dec.imm;
        end else begin
            op_b = rf_b;
        end
    end

endmodule

/* src/pipe_reg.sv */
`timescale 1ns/100ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     load,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= load && in_valid; // no load means bubble
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= in_data;
        end
    end

endmodule

/* src/reg_file.sv */
`timescale 1ns/100ps

module reg_file import exec_pkg::*; (
    input  logic      clk,
    input  reg_addr_t raddr_a,
    input  reg_addr_t raddr_b,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    input  logic      wen,
    output word_t     rdata_a,
    output word_t     rdata_b
);

    word_t regs [0:31];

    always_ff @(posedge clk) begin
        if (wen && (waddr != '0)) begin // x0 writes dropped
            regs[waddr] <= wdata;
        end
    end

    // x0 hardwired to zero
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

/* tb/int_exec_checker.sv */
`timescale 1ns/100ps

module int_exec_checker import exec_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      wb_load,
    input logic      rf_wen,
    input logic      fwd_a,
    input logic      fwd_b,
    input logic      halt,
    input reg_addr_t wb_rd_q
);

    int fail_count = 0; // summed into the testbench error count

    halt_sticky: assert property (@(posedge clk) (rst && halt) |=> halt)
        else begin
            $error("halt dropped while reset was inactive");
            fail_count++;
        end

    no_write_in_halt: assert property (@(posedge clk) !(rf_wen && halt))
        else begin
            $error("register file written while halted");
            fail_count++;
        end

    no_fwd_from_x0: assert property (@(posedge clk) (wb_rd_q == '0) |-> !(fwd_a || fwd_b))
        else begin
            $error("forwarding selected from x0");
            fail_count++;
        end

    clean_after_reset: assert property (@(posedge clk) !rst |=> (!halt && !wb_load))
        else begin
            $error("halt or wb_load high right after reset");
            fail_count++;
        end

endmodule

/* tb/tb_int_exec_core.sv */
`timescale 1ns/100ps

module tb_int_exec_core import exec_pkg::*; ();

    localparam int k_wb   = 0; // result expected
    localparam int k_none = 1; // dropped behind a halt
    localparam int k_bad  = 2; // illegal word
    localparam int g_rand = 0;
    localparam int g_none = 1;
    localparam int g_one  = 2;

    typedef struct {
        word_t     word;
        word_t     pc;
        logic      exp_wb;
        logic      illegal;
        logic      reset_before;
        reg_addr_t rd;
        word_t     data;
        int        gap_sel;
    } entry_t;

    logic      clk;
    logic      rst;
    logic      inst_valid;
    word_t     inst_word;
    word_t     inst_pc;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;
    logic      halt;

    entry_t tbl[$];
    entry_t pending[$]; // results still to come out of the pipe
    word_t  next_pc     = 32'h0000_0100;
    logic   reset_next  = 1'b0;
    logic   table_ready = 1'b0;
    int     checks      = 0;
    int     errors      = 0;

    int_exec_core uut (
        .clk(clk), .rst(rst), .inst_valid(inst_valid),
        .inst_word(inst_word), .inst_pc(inst_pc),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data), .halt(halt)
    );

    bind exec_ctrl int_exec_checker chk0 (
        .clk(clk), .rst(rst), .wb_load(wb_load), .rf_wen(rf_wen),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .halt(halt), .wb_rd_q(wb_rd_q)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_reg};
    endfunction

    function automatic word_t i_type(input logic [2:0] f3, input int rd, input int rs1,
                                     input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op_imm};
    endfunction

    function automatic word_t u_type(input logic [6:0] opcode, input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], opcode};
    endfunction

    task automatic add_entry(input word_t word, input int kind, input int rd,
                             input word_t data, input int gap_sel);
        entry_t e;
        e.word         = word;
        e.pc           = next_pc;
        e.exp_wb       = (kind == k_wb);
        e.illegal      = (kind == k_bad);
        e.reset_before = reset_next;
        e.rd           = rd[4:0];
        e.data         = data;
        e.gap_sel      = gap_sel;
        reset_next     = 1'b0;
        next_pc        = next_pc + 32'd4;
        tbl.push_back(e);
    endtask

    task automatic build_table();
        add_entry(i_type(f3_add_sub, 1, 0, 100), k_wb, 1, 32'h0000_0064, g_rand);
        add_entry(i_type(f3_add_sub, 2, 0, -7), k_wb, 2, 32'hFFFF_FFF9, g_rand);
        add_entry(u_type(op_lui, 3, 'hABCDE), k_wb, 3, 32'hABCD_E000, g_rand);
        add_entry(r_type(funct7_base, f3_add_sub, 4, 1, 2), k_wb, 4, 32'h0000_005D, g_rand);
        add_entry(r_type(funct7_alt, f3_add_sub, 5, 1, 2), k_wb, 5, 32'h0000_006B, g_rand);
        add_entry(i_type(f3_add_sub, 6, 0, 4), k_wb, 6, 32'h0000_0004, g_rand);
        add_entry(r_type(funct7_base, f3_sll, 7, 1, 6), k_wb, 7, 32'h0000_0640, g_rand);
        add_entry(r_type(funct7_base, f3_srl_sra, 8, 2, 6), k_wb, 8, 32'h0FFF_FFFF, g_rand);
        add_entry(r_type(funct7_alt, f3_srl_sra, 9, 2, 6), k_wb, 9, 32'hFFFF_FFFF, g_rand);
        add_entry(r_type(funct7_base, f3_slt, 10, 2, 1), k_wb, 10, 32'h0000_0001, g_rand);
        add_entry(r_type(funct7_base, f3_sltu, 11, 2, 1), k_wb, 11, 32'h0000_0000, g_rand);
        add_entry(r_type(funct7_base, f3_xor, 12, 1, 2), k_wb, 12, 32'hFFFF_FF9D, g_rand);
        add_entry(r_type(funct7_base, f3_or, 13, 1, 3), k_wb, 13, 32'hABCD_E064, g_rand);
        add_entry(r_type(funct7_base, f3_and, 14, 2, 1), k_wb, 14, 32'h0000_0060, g_rand);
        // producer and consumer back to back, then again through the register file
        add_entry(i_type(f3_add_sub, 15, 0, 21), k_wb, 15, 32'h0000_0015, g_rand);
        add_entry(r_type(funct7_base, f3_add_sub, 16, 15, 15), k_wb, 16, 32'h0000_002A, g_none);
        add_entry(i_type(f3_add_sub, 15, 0, -1), k_wb, 15, 32'hFFFF_FFFF, g_rand);
        add_entry(i_type(f3_add_sub, 15, 0, 21), k_wb, 15, 32'h0000_0015, g_rand);
        add_entry(r_type(funct7_base, f3_add_sub, 16, 15, 15), k_wb, 16, 32'h0000_002A, g_one);
        add_entry(r_type(funct7_alt, f3_add_sub, 17, 1, 16), k_wb, 17, 32'h0000_003A, g_none);
        next_pc = 32'h8000_0000;
        add_entry(u_type(op_auipc, 19, 'h12345), k_wb, 19, 32'h9234_5000, g_rand);
        add_entry(u_type(op_auipc, 20, 'hFFFFF), k_wb, 20, 32'h7FFF_F004, g_rand);
        add_entry(i_type(f3_add_sub, 21, 0, 3), k_wb, 21, 32'h0000_0003, g_rand);
        add_entry(i_type(f3_add_sub, 0, 0, 5), k_wb, 0, 32'h0000_0005, g_rand);
        add_entry(r_type(funct7_base, f3_add_sub, 22, 0, 0), k_wb, 22, 32'h0000_0000, g_none);
        add_entry(i_type(f3_srl_sra, 23, 2, 'h401), k_wb, 23, 32'hFFFF_FFFC, g_rand);
        add_entry(i_type(f3_or, 24, 1, -256), k_wb, 24, 32'hFFFF_FF64, g_rand);
        add_entry(32'h0020_A023, k_bad, 0, 32'h0, g_rand); // sw, not handled here
        add_entry(i_type(f3_add_sub, 25, 0, 9), k_none, 25, 32'h0, g_none);
        add_entry(u_type(op_lui, 26, 'h11111), k_none, 26, 32'h0, g_rand);
        reset_next = 1'b1;
        add_entry(i_type(f3_add_sub, 27, 0, 'h123), k_wb, 27, 32'h0000_0123, g_rand);
        add_entry(r_type(7'b0000010, f3_add_sub, 28, 1, 2), k_bad, 28, 32'h0, g_none);
        add_entry(i_type(f3_add_sub, 28, 0, 1), k_none, 28, 32'h0, g_none);
        add_entry(r_type(funct7_alt, f3_add_sub, 29, 1, 2), k_none, 29, 32'h0, g_rand);
    endtask

    task automatic check_value(input string what, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic apply_reset();
        rst        = 1'b0;
        inst_valid = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b1;
        check_value("halt after reset", {31'b0, halt}, 32'h0);
        check_value("wb_valid after reset", {31'b0, wb_valid}, 32'h0);
    endtask

    task automatic drain_pipeline(input logic halt_exp);
        repeat (4) @(posedge clk);
        #1;
        check_value("halt", {31'b0, halt}, {31'b0, halt_exp});
        if (pending.size() != 0) begin
            errors++;
            $display("error at %0t: %0d expected write-backs never came out",
                     $time, pending.size());
            pending.delete();
        end
    endtask

    // one result per wb_valid pulse, in issue order
    initial begin
        entry_t e;
        forever begin
            @(negedge clk);
            if (rst === 1'b1 && wb_valid === 1'b1) begin
                if (pending.size() == 0) begin
                    errors++;
                    $display("error at %0t: write-back to x%0d with no result expected",
                             $time, wb_rd);
                end else begin
                    e = pending.pop_front();
                    check_value("wb_rd", {27'b0, wb_rd}, {27'b0, e.rd});
                    check_value("wb_data", wb_data, e.data);
                end
            end
        end
    end

    initial begin
        int limit;
        wait (table_ready);
        limit = tbl.size() * 4 + 50;
        repeat (limit) @(posedge clk);
        $display("timeout: run did not finish within %0d clock cycles", limit);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int   gap;
        logic seen_illegal;
        rst        = 1'b0;
        inst_valid = 1'b0;
        inst_word  = '0;
        inst_pc    = '0;
        void'($urandom(13));
        build_table();
        table_ready = 1'b1;
        apply_reset();
        seen_illegal = 1'b0;
        for (int i = 0; i < tbl.size(); i++) begin
            if (tbl[i].reset_before) begin
                drain_pipeline(seen_illegal);
                apply_reset();
                seen_illegal = 1'b0;
            end
            case (tbl[i].gap_sel)
                g_none:  gap = 0;
                g_one:   gap = 1;
                default: gap = $urandom % 3;
            endcase
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            inst_valid = 1'b1;
            inst_word  = tbl[i].word;
            inst_pc    = tbl[i].pc;
            if (tbl[i].exp_wb) begin
                pending.push_back(tbl[i]);
            end
            @(posedge clk);
            #1;
            inst_valid = 1'b0;
            check_value("halt", {31'b0, halt}, {31'b0, seen_illegal}); // older word was illegal
            if (tbl[i].illegal) begin
                seen_illegal = 1'b1;
            end
        end
        drain_pipeline(seen_illegal);
        errors = errors + uut.ctrl0.chk0.fail_count;
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
